// ==== source/rename_pkg.sv ====
package rename_pkg;

    // rename group width and retire width
    localparam int MACHINE_WIDTH = 2;
    localparam int RELEASE_PORTS = 2;

    // reorder buffer doubles as physical register file
    // depth must stay a power of two, tags wrap freely
    localparam int ROB_DEPTH = 16;
    localparam int TAG_W = 4;

    // architectural register index
    localparam int AREG_W = 7;
    localparam int BANK_W = 2;
    localparam int NUM_W = AREG_W - BANK_W;

    // table covers gprs 0..31 plus hi/lo at the top
    localparam int TABLE_LEN = 67;

    // special indices
    localparam logic [AREG_W-1:0] HI_IDX = 7'd65;
    localparam logic [AREG_W-1:0] LO_IDX = 7'd66;
    // destination-only code, no table slot of its own
    localparam logic [AREG_W-1:0] HILO_IDX = 7'd67;

    // same codes seen through the bank/number view
    localparam logic [BANK_W-1:0] GPR_BANK = 2'd0;
    localparam logic [BANK_W-1:0] HILO_BANK = HILO_IDX[AREG_W-1:NUM_W];
    localparam logic [NUM_W-1:0] HILO_NUM = HILO_IDX[NUM_W-1:0];

    // bank/number split of a register index
    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [NUM_W-1:0]  num;
    } areg_fields_t;

    // raw view addresses the table
    // field view picks out r0 and the hi/lo pair code
    typedef union packed {
        logic [AREG_W-1:0] raw;
        areg_fields_t      f;
    } areg_u;

    // one alias table entry
    // valid low means value lives in the architectural file
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } map_entry_t;

endpackage

// ==== source/rename_intf.sv ====
`timescale 1ns/100ps

// rename group between top, ring and alias table
interface rename_intf;
    // per slot, from the top
    logic [rename_pkg::MACHINE_WIDTH-1:0]            instr_valid;
    rename_pkg::areg_u [rename_pkg::MACHINE_WIDTH-1:0] src1;
    rename_pkg::areg_u [rename_pkg::MACHINE_WIDTH-1:0] src2;
    rename_pkg::areg_u [rename_pkg::MACHINE_WIDTH-1:0] dst;

    // per slot, from the ring
    // taken is instr_valid qualified by room
    logic [rename_pkg::MACHINE_WIDTH-1:0]                       instr_taken;
    logic [rename_pkg::MACHINE_WIDTH-1:0][rename_pkg::TAG_W-1:0] new_tag;

    // per slot, from the alias table
    rename_pkg::map_entry_t [rename_pkg::MACHINE_WIDTH-1:0] src1_map;
    rename_pkg::map_entry_t [rename_pkg::MACHINE_WIDTH-1:0] src2_map;
    rename_pkg::map_entry_t [rename_pkg::MACHINE_WIDTH-1:0] dst_map;

    modport ring (input instr_valid, dst, output instr_taken, new_tag);
    modport rat (
        input  instr_taken, src1, src2, dst, new_tag,
        output src1_map, src2_map, dst_map
    );
endinterface

// retirement, ring to alias table
interface retire_intf;
    logic [rename_pkg::RELEASE_PORTS-1:0]                       retire_valid;
    rename_pkg::areg_u [rename_pkg::RELEASE_PORTS-1:0]           retire_dst;
    logic [rename_pkg::RELEASE_PORTS-1:0][rename_pkg::TAG_W-1:0] retire_tag;

    modport ring (output retire_valid, retire_dst, retire_tag);
    modport rat (input retire_valid, retire_dst, retire_tag);
endinterface

// ==== source/rat.sv ====
`timescale 1ns/100ps

module rat (
    input logic     clk,
    input logic     rst_n,
    input logic     flush,
    rename_intf.rat ren,
    retire_intf.rat ret
);

    // current table and its next-cycle image
    rename_pkg::map_entry_t table_q [rename_pkg::TABLE_LEN];
    rename_pkg::map_entry_t table_d [rename_pkg::TABLE_LEN];

    // raw index has a slot in the table
    function automatic logic in_table(input rename_pkg::areg_u r);
        return int'(r.raw) < rename_pkg::TABLE_LEN;
    endfunction

    // hi/lo pair destination code
    function automatic logic is_pair(input rename_pkg::areg_u r);
        return (r.f.bank == rename_pkg::HILO_BANK) && (r.f.num == rename_pkg::HILO_NUM);
    endfunction

    // r0, hardwired, never mapped
    function automatic logic is_zero(input rename_pkg::areg_u r);
        return (r.f.bank == rename_pkg::GPR_BANK) && (r.f.num == '0);
    endfunction

    always_comb begin
        table_d = table_q;

        // retire pass first
        // clear only if no younger producer took the entry since
        for (int p = 0; p < rename_pkg::RELEASE_PORTS; p++) begin
            if (ret.retire_valid[p]) begin
                if (is_pair(ret.retire_dst[p])) begin
                    // hi and lo may have diverged, test each
                    if (table_d[rename_pkg::HI_IDX].valid &&
                        table_d[rename_pkg::HI_IDX].tag == ret.retire_tag[p]) begin
                        table_d[rename_pkg::HI_IDX] = '0;
                    end
                    if (table_d[rename_pkg::LO_IDX].valid &&
                        table_d[rename_pkg::LO_IDX].tag == ret.retire_tag[p]) begin
                        table_d[rename_pkg::LO_IDX] = '0;
                    end
                end else if (in_table(ret.retire_dst[p])) begin
                    if (table_d[ret.retire_dst[p].raw].valid &&
                        table_d[ret.retire_dst[p].raw].tag == ret.retire_tag[p]) begin
                        table_d[ret.retire_dst[p].raw] = '0;
                    end
                end
            end
        end

        // rename pass, slot order
        // sources read before own write, after lower slots' writes
        for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
            ren.src1_map[s] = in_table(ren.src1[s]) ? table_d[ren.src1[s].raw] : '0;
            ren.src2_map[s] = in_table(ren.src2[s]) ? table_d[ren.src2[s].raw] : '0;

            if (ren.instr_taken[s]) begin
                if (is_pair(ren.dst[s])) begin
                    // mult/div result, both halves get the tag
                    table_d[rename_pkg::HI_IDX] = '{valid: 1'b1, tag: ren.new_tag[s]};
                    table_d[rename_pkg::LO_IDX] = '{valid: 1'b1, tag: ren.new_tag[s]};
                end else if (!is_zero(ren.dst[s]) && in_table(ren.dst[s])) begin
                    table_d[ren.dst[s].raw] = '{valid: 1'b1, tag: ren.new_tag[s]};
                end
            end
        end

        // destination view after the whole group
        for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
            if (is_pair(ren.dst[s])) begin
                // pair reported through hi
                ren.dst_map[s] = table_d[rename_pkg::HI_IDX];
            end else if (in_table(ren.dst[s])) begin
                ren.dst_map[s] = table_d[ren.dst[s].raw];
            end else begin
                ren.dst_map[s] = '0;
            end
        end
    end

    // flush drops every speculative mapping
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            table_q <= '{default: '0};
        end else begin
            table_q <= table_d;
        end
    end

endmodule

// ==== source/rob_ring.sv ====
`timescale 1ns/100ps

module rob_ring (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    rename_intf.ring                    ren,
    retire_intf.ring                    ret,
    input  logic                        wb_valid,
    input  logic [rename_pkg::TAG_W-1:0] wb_tag,
    output logic                        rob_room
);

    // head = oldest in flight, tail = next free
    logic [rename_pkg::TAG_W-1:0] head;
    logic [rename_pkg::TAG_W-1:0] tail;
    // 0..ROB_DEPTH, one bit wider than a tag
    logic [rename_pkg::TAG_W:0]   count;

    // per-entry state
    logic [rename_pkg::ROB_DEPTH-1:0] done;
    rename_pkg::areg_u                dst_mem [rename_pkg::ROB_DEPTH];

    // allocation side
    logic [rename_pkg::MACHINE_WIDTH-1:0] taken;
    logic [rename_pkg::TAG_W:0]           n_alloc;

    // retire side
    logic [rename_pkg::RELEASE_PORTS-1:0][rename_pkg::TAG_W-1:0] ret_ptr;
    logic [rename_pkg::RELEASE_PORTS-1:0]                       ret_ok;
    logic                                                       ret_chain;
    logic [rename_pkg::TAG_W:0]                                 n_ret;

    // room for a full group
    assign rob_room = int'(count) <= rename_pkg::ROB_DEPTH - rename_pkg::MACHINE_WIDTH;

    // consecutive tags to valid slots only
    always_comb begin
        n_alloc = '0;
        for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
            taken[s] = ren.instr_valid[s] && rob_room;
            ren.new_tag[s] = tail + n_alloc[rename_pkg::TAG_W-1:0];
            if (taken[s]) begin
                n_alloc = n_alloc + 1'b1;
            end
        end
    end

    // rat writes only what the ring accepted
    assign ren.instr_taken = taken;

    // oldest entries, stop at the first one not done
    always_comb begin
        n_ret = '0;
        ret_chain = 1'b1;
        for (int p = 0; p < rename_pkg::RELEASE_PORTS; p++) begin
            ret_ptr[p] = head + rename_pkg::TAG_W'(p);
            ret_ok[p] = ret_chain && (int'(count) > p) && done[ret_ptr[p]];
            ret_chain = ret_ok[p];
            if (ret_ok[p]) begin
                n_ret = n_ret + 1'b1;
            end
        end
    end

    assign ret.retire_valid = ret_ok;
    assign ret.retire_tag = ret_ptr;

    always_comb begin
        for (int p = 0; p < rename_pkg::RELEASE_PORTS; p++) begin
            ret.retire_dst[p] = dst_mem[ret_ptr[p]];
        end
    end

    // pointers, count and done bits
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            done <= '0;
        end else begin
            head <= head + n_ret[rename_pkg::TAG_W-1:0];
            tail <= tail + n_alloc[rename_pkg::TAG_W-1:0];
            count <= count + n_alloc - n_ret;
            // completion, one per cycle
            if (wb_valid) begin
                done[wb_tag] <= 1'b1;
            end
            // freed entries start clean
            for (int p = 0; p < rename_pkg::RELEASE_PORTS; p++) begin
                if (ret_ok[p]) begin
                    done[ret_ptr[p]] <= 1'b0;
                end
            end
            // fresh allocation wins over any stale strobe
            for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
                if (taken[s]) begin
                    done[ren.new_tag[s]] <= 1'b0;
                end
            end
        end
    end

    // destination record, payload only
    always_ff @(posedge clk) begin
        for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
            if (taken[s]) begin
                dst_mem[ren.new_tag[s]] <= ren.dst[s];
            end
        end
    end

endmodule

// ==== source/rename_unit.sv ====
`timescale 1ns/100ps

module rename_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,

    // rename group, one entry per slot
    input  logic [rename_pkg::MACHINE_WIDTH-1:0]                        in_valid,
    input  logic [rename_pkg::MACHINE_WIDTH-1:0][rename_pkg::AREG_W-1:0] in_src1,
    input  logic [rename_pkg::MACHINE_WIDTH-1:0][rename_pkg::AREG_W-1:0] in_src2,
    input  logic [rename_pkg::MACHINE_WIDTH-1:0][rename_pkg::AREG_W-1:0] in_dst,

    // completion strobe
    input  logic                        wb_valid,
    input  logic [rename_pkg::TAG_W-1:0] wb_tag,

    output logic                                                        rob_room,
    output logic [rename_pkg::MACHINE_WIDTH-1:0][rename_pkg::TAG_W-1:0]  new_tag,
    output rename_pkg::map_entry_t [rename_pkg::MACHINE_WIDTH-1:0]       src1_map,
    output rename_pkg::map_entry_t [rename_pkg::MACHINE_WIDTH-1:0]       src2_map,
    output rename_pkg::map_entry_t [rename_pkg::MACHINE_WIDTH-1:0]       dst_map,

    // retirement, oldest on port 0
    output logic [rename_pkg::RELEASE_PORTS-1:0]                        retire_valid,
    output logic [rename_pkg::RELEASE_PORTS-1:0][rename_pkg::AREG_W-1:0] retire_dst,
    output logic [rename_pkg::RELEASE_PORTS-1:0][rename_pkg::TAG_W-1:0]  retire_tag
);

    rename_intf ren_if ();
    retire_intf ret_if ();

    // group in
    assign ren_if.instr_valid = in_valid;
    assign ren_if.src1 = in_src1;
    assign ren_if.src2 = in_src2;
    assign ren_if.dst = in_dst;

    // group results out
    assign new_tag = ren_if.new_tag;
    assign src1_map = ren_if.src1_map;
    assign src2_map = ren_if.src2_map;
    assign dst_map = ren_if.dst_map;

    // retire ports out, also feed the table
    assign retire_valid = ret_if.retire_valid;
    assign retire_dst = ret_if.retire_dst;
    assign retire_tag = ret_if.retire_tag;

    rob_ring u_rob_ring (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .ren      (ren_if.ring),
        .ret      (ret_if.ring),
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .rob_room (rob_room)
    );

    rat u_rat (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .ren   (ren_if.rat),
        .ret   (ret_if.rat)
    );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps

// free-running clock, 8 ns period
module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end
endmodule

// ==== dv/rename_checker.sv ====
`timescale 1ns/100ps

module rename_checker (
    input logic                                                        clk,
    input logic                                                        rst_n,
    input logic                                                        flush,
    input logic                                                        rob_room,
    input logic [rename_pkg::MACHINE_WIDTH-1:0][rename_pkg::TAG_W-1:0] new_tag,
    input logic [rename_pkg::RELEASE_PORTS-1:0]                        retire_valid,
    input logic [rename_pkg::RELEASE_PORTS-1:0][rename_pkg::TAG_W-1:0] retire_tag
);
    // read by the testbench at the end of the run
    int fail_count = 0;

    // ring comes back empty after reset or flush
    quiet_after_clear: assert property (@(posedge clk)
        (!rst_n || flush) |=> (retire_valid == '0))
        else begin
            fail_count++;
            $error("retire_valid high in the cycle after reset or flush");
        end

    // oldest entry always on port 0
    port1_needs_port0: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid[1] |-> retire_valid[0])
        else begin
            fail_count++;
            $error("retire port 1 valid without port 0");
        end

    // second retiree is the next ring entry
    port1_tag_follows: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid[1] |-> (retire_tag[1] == rename_pkg::TAG_W'(retire_tag[0] + 1'b1)))
        else begin
            fail_count++;
            $error("retire port 1 tag is not port 0 tag plus one");
        end

    // new_tag[0] is the tail, frozen while there is no room
    tail_held_without_room: assert property (@(posedge clk)
        (rst_n && !flush && !rob_room) |=> (new_tag[0] == $past(new_tag[0])))
        else begin
            fail_count++;
            $error("tags handed out while rob_room was low");
        end
endmodule

bind rename_unit rename_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .rob_room     (rob_room),
    .new_tag      (new_tag),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag)
);

// ==== dv/rename_tb.sv ====
`timescale 1ns/100ps

module rename_tb;

    logic clk;
    logic rst_n;
    logic flush;
    logic [rename_pkg::MACHINE_WIDTH-1:0] in_valid;
    logic [rename_pkg::MACHINE_WIDTH-1:0][rename_pkg::AREG_W-1:0] in_src1, in_src2, in_dst;
    logic wb_valid;
    logic [rename_pkg::TAG_W-1:0] wb_tag;
    logic rob_room;
    logic [rename_pkg::MACHINE_WIDTH-1:0][rename_pkg::TAG_W-1:0] new_tag;
    rename_pkg::map_entry_t [rename_pkg::MACHINE_WIDTH-1:0] src1_map, src2_map, dst_map;
    logic [rename_pkg::RELEASE_PORTS-1:0] retire_valid;
    logic [rename_pkg::RELEASE_PORTS-1:0][rename_pkg::AREG_W-1:0] retire_dst;
    logic [rename_pkg::RELEASE_PORTS-1:0][rename_pkg::TAG_W-1:0] retire_tag;

    // model state, table and ring as seen after the last edge
    rename_pkg::map_entry_t m_table [rename_pkg::TABLE_LEN];
    rename_pkg::map_entry_t t_work [rename_pkg::TABLE_LEN];
    logic [rename_pkg::TAG_W-1:0] m_head, m_tail;
    logic [rename_pkg::ROB_DEPTH-1:0] m_done;
    logic [rename_pkg::AREG_W-1:0] m_dst [rename_pkg::ROB_DEPTH];
    int m_count;

    // occupancy as seen on the DUT's room and retire ports
    int seen_count;

    // expected outputs for the current cycle
    logic exp_room;
    logic [rename_pkg::MACHINE_WIDTH-1:0] exp_taken;
    logic [rename_pkg::MACHINE_WIDTH-1:0][rename_pkg::TAG_W-1:0] exp_new_tag;
    rename_pkg::map_entry_t [rename_pkg::MACHINE_WIDTH-1:0] exp_src1, exp_src2, exp_dst;
    logic [rename_pkg::RELEASE_PORTS-1:0] exp_rv;
    logic [rename_pkg::RELEASE_PORTS-1:0][rename_pkg::AREG_W-1:0] exp_rdst;
    logic [rename_pkg::RELEASE_PORTS-1:0][rename_pkg::TAG_W-1:0] exp_rtag;

    logic [31:0] lfsr_state;
    int n_checks, n_errors, timeouts;

    tb_clock u_clock (.clk(clk));

    rename_unit UUT (.*);

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // mostly low gprs so producers collide, some hi/lo and stray codes
    function automatic logic [rename_pkg::AREG_W-1:0] pick_reg();
        case (rand_bits(3))
            5: return rename_pkg::HI_IDX;
            6: return rename_pkg::LO_IDX;
            7: return rand_bits(1) ? rename_pkg::HILO_IDX : 7'(rand_bits(7));
            default: return 7'(rand_bits(4));
        endcase
    endfunction

    function automatic void reset_model();
        m_table = '{default: '0};
        m_head = '0;
        m_tail = '0;
        m_count = 0;
        m_done = '0;
    endfunction

    function automatic rename_pkg::map_entry_t lookup(input logic [rename_pkg::AREG_W-1:0] r);
        if (int'(r) < rename_pkg::TABLE_LEN) begin
            return t_work[r];
        end
        return '0;
    endfunction

    // clear only while the entry still names the retiring tag
    function automatic void release_reg(input int idx, input logic [rename_pkg::TAG_W-1:0] tag);
        if (t_work[idx].valid && t_work[idx].tag == tag) begin
            t_work[idx] = '0;
        end
    endfunction

    // expected outputs from model and inputs, then advance the model one edge
    function automatic void reference_step(input logic clear);
        int n_ret;
        int k;
        logic [rename_pkg::TAG_W-1:0] tag;
        n_ret = 0;
        t_work = m_table;
        for (int p = 0; p < rename_pkg::RELEASE_PORTS; p++) begin
            tag = m_head + rename_pkg::TAG_W'(p);
            exp_rtag[p] = tag;
            exp_rdst[p] = m_dst[tag];
            // contiguous from the head, in flight and completed
            exp_rv[p] = (n_ret == p) && (m_count > p) && m_done[tag];
            if (exp_rv[p]) begin
                n_ret++;
                if (exp_rdst[p] == rename_pkg::HILO_IDX) begin
                    release_reg(rename_pkg::HI_IDX, tag);
                    release_reg(rename_pkg::LO_IDX, tag);
                end else if (int'(exp_rdst[p]) < rename_pkg::TABLE_LEN) begin
                    release_reg(exp_rdst[p], tag);
                end
            end
        end
        exp_room = (rename_pkg::ROB_DEPTH - m_count) >= rename_pkg::MACHINE_WIDTH;
        k = 0;
        for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
            exp_src1[s] = lookup(in_src1[s]);
            exp_src2[s] = lookup(in_src2[s]);
            exp_taken[s] = in_valid[s] && exp_room;
            exp_new_tag[s] = m_tail + rename_pkg::TAG_W'(k);
            if (exp_taken[s]) begin
                k++;
                if (in_dst[s] == rename_pkg::HILO_IDX) begin
                    t_work[rename_pkg::HI_IDX] = '{valid: 1'b1, tag: exp_new_tag[s]};
                    t_work[rename_pkg::LO_IDX] = '{valid: 1'b1, tag: exp_new_tag[s]};
                end else if (in_dst[s] != '0 && int'(in_dst[s]) < rename_pkg::TABLE_LEN) begin
                    t_work[in_dst[s]] = '{valid: 1'b1, tag: exp_new_tag[s]};
                end
            end
        end
        // pair shown through hi
        for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
            exp_dst[s] = (in_dst[s] == rename_pkg::HILO_IDX) ? t_work[rename_pkg::HI_IDX]
                                                             : lookup(in_dst[s]);
        end
        if (clear) begin
            reset_model();
        end else begin
            m_table = t_work;
            if (wb_valid) begin
                m_done[wb_tag] = 1'b1;
            end
            for (int p = 0; p < rename_pkg::RELEASE_PORTS; p++) begin
                if (exp_rv[p]) begin
                    m_done[exp_rtag[p]] = 1'b0;
                end
            end
            for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
                if (exp_taken[s]) begin
                    m_done[exp_new_tag[s]] = 1'b0;
                    m_dst[exp_new_tag[s]] = in_dst[s];
                end
            end
            m_head = m_head + rename_pkg::TAG_W'(n_ret);
            m_tail = m_tail + rename_pkg::TAG_W'(k);
            m_count = m_count + k - n_ret;
        end
    endfunction

    // accepted slots in, retire ports out
    function automatic void count_occupancy();
        if (flush) begin
            seen_count = 0;
        end else begin
            for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
                if (in_valid[s] && rob_room) begin
                    seen_count++;
                end
            end
            for (int p = 0; p < rename_pkg::RELEASE_PORTS; p++) begin
                if (retire_valid[p]) begin
                    seen_count--;
                end
            end
        end
    endfunction

    task automatic check_value(input string name, input int idx,
                               input logic [15:0] expv, input logic [15:0] actv);
        n_checks++;
        if (actv !== expv) begin
            n_errors++;
            $display("FAIL %0t %s[%0d] expected %h got %h", $time, name, idx, expv, actv);
        end
    endtask

    task automatic compare_outputs();
        check_value("rob_room", 0, exp_room, rob_room);
        for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
            if (exp_taken[s]) begin
                check_value("new_tag", s, exp_new_tag[s], new_tag[s]);
            end
            check_value("src1_map", s, exp_src1[s], src1_map[s]);
            check_value("src2_map", s, exp_src2[s], src2_map[s]);
            check_value("dst_map", s, exp_dst[s], dst_map[s]);
        end
        for (int p = 0; p < rename_pkg::RELEASE_PORTS; p++) begin
            check_value("retire_valid", p, exp_rv[p], retire_valid[p]);
            if (exp_rv[p]) begin
                check_value("retire_tag", p, exp_rtag[p], retire_tag[p]);
                check_value("retire_dst", p, exp_rdst[p], retire_dst[p]);
            end
        end
    endtask

    // compare mid low phase, after falling-edge stimulus settles
    always @(negedge clk) begin
        #3;
        if (!rst_n) begin
            reset_model();
            seen_count = 0;
        end else begin
            reference_step(flush);
            compare_outputs();
            count_occupancy();
        end
    end

    // oldest-first search from a random offset for an entry still pending
    function automatic logic find_pending(input int start, output logic [rename_pkg::TAG_W-1:0] tag);
        int off;
        tag = '0;
        for (int i = 0; i < rename_pkg::ROB_DEPTH; i++) begin
            off = (start + i) % rename_pkg::ROB_DEPTH;
            if (off < m_count && !m_done[m_head + rename_pkg::TAG_W'(off)]) begin
                tag = m_head + rename_pkg::TAG_W'(off);
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic drive_group(input logic [1:0] valid, input logic [1:0][6:0] s1, s2, d);
        @(negedge clk);
        in_valid = valid;
        in_src1 = s1;
        in_src2 = s2;
        in_dst = d;
        wb_valid = 1'b0;
        flush = 1'b0;
    endtask

    // weights out of 4, 4, 32
    task automatic drive_random(input int alloc_w, input int wb_w, input int flush_w);
        logic [rename_pkg::TAG_W-1:0] tag;
        @(negedge clk);
        for (int s = 0; s < rename_pkg::MACHINE_WIDTH; s++) begin
            in_valid[s] = rand_bits(2) < alloc_w;
            in_src1[s] = pick_reg();
            in_src2[s] = pick_reg();
            in_dst[s] = pick_reg();
        end
        wb_valid = (rand_bits(2) < wb_w) && find_pending(rand_bits(4), tag);
        wb_tag = wb_valid ? tag : 4'(rand_bits(4));
        flush = rand_bits(5) < flush_w;
    endtask

    // allocate at full rate with no completions until room runs out
    task automatic fill_ring();
        int cycles;
        cycles = 0;
        while (rob_room !== 1'b0 && cycles < 40) begin
            drive_random(4, 0, 0);
            cycles++;
        end
        if (rob_room !== 1'b0) begin
            $display("timeout: rob_room stayed high while the ring was filled");
            timeouts++;
        end
    endtask

    // complete out of order until the DUT has retired every entry
    task automatic drain_ring();
        int cycles;
        cycles = 0;
        while (seen_count != 0 && cycles < 80) begin
            drive_random(0, 4, 0);
            cycles++;
        end
        if (seen_count != 0) begin
            $display("timeout: ring still holds %0d entries after draining", seen_count);
            timeouts++;
        end
    endtask

    initial begin
        lfsr_state = 32'hcacf0051;
        n_checks = 0;
        n_errors = 0;
        timeouts = 0;
        seen_count = 0;
        rst_n = 1'b0;
        flush = 1'b0;
        in_valid = '0;
        in_src1 = '0;
        in_src2 = '0;
        in_dst = '0;
        wb_valid = 1'b0;
        wb_tag = '0;
        reset_model();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        // slot 1 reads and rewrites slot 0's destination
        drive_group(2'b11, {7'd5, 7'd0}, {7'd5, 7'd3}, {7'd5, 7'd5});
        // pair code in slot 0, hi and lo read by slot 1
        drive_group(2'b11, {rename_pkg::HI_IDX, 7'd5}, {rename_pkg::LO_IDX, 7'd0},
                    {7'd9, rename_pkg::HILO_IDX});
        // later lookups, nothing allocated
        drive_group(2'b00, {7'd5, rename_pkg::HI_IDX}, {7'd9, rename_pkg::LO_IDX},
                    {rename_pkg::HILO_IDX, 7'd0});
        repeat (400) drive_random(3, 2, 0);
        fill_ring();
        drain_ring();
        repeat (300) drive_random(3, 2, 1);
        // flush a busy ring, then look up with nothing allocated
        repeat (6) drive_random(4, 1, 0);
        drive_random(4, 2, 32);
        repeat (4) drive_random(0, 0, 0);
        fill_ring();
        drain_ring();
        drive_random(0, 0, 0);
        @(negedge clk);
        #4;
        $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 n_checks, n_errors, timeouts, UUT.u_checker.fail_count);
        if (n_errors == 0 && timeouts == 0 && UUT.u_checker.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== rename_unit.f ====
source/rename_pkg.sv
source/rename_intf.sv
source/rat.sv
source/rob_ring.sv
source/rename_unit.sv
dv/tb_clock.sv
dv/rename_checker.sv
dv/rename_tb.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
RUN_FLAGS = +verilator+error+limit+1000
TOP       = rename_tb
FILELIST  = rename_unit.f

BUILD_DIR = obj_dir
BIN       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
